/* isaPkg.sv */
package isaPkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] instrWord_t;
    typedef logic [4:0]  regIdx_t;

    localparam regIdx_t zeroReg    = 5'd31;
    localparam word_t   instrBytes = 64'd4;

    ////////////////////////////////////////////////////
    // Opcodes, grouped by field width
    ////////////////////////////////////////////////////

    // R and D format
    localparam logic [10:0] opAdd  = 11'b10001011000;
    localparam logic [10:0] opSub  = 11'b11001011000;
    localparam logic [10:0] opAnd  = 11'b10001010000;
    localparam logic [10:0] opOrr  = 11'b10101010000;
    localparam logic [10:0] opEor  = 11'b11001010000;
    localparam logic [10:0] opLdur = 11'b11111000010;
    localparam logic [10:0] opStur = 11'b11111000000;

    // I format
    localparam logic [9:0] opAddi = 10'b1001000100;
    localparam logic [9:0] opSubi = 10'b1101000100;
    localparam logic [9:0] opAndi = 10'b1001001000;
    localparam logic [9:0] opOrri = 10'b1011001000;
    localparam logic [9:0] opEori = 10'b1101001000;

    // CB and B format
    localparam logic [7:0] opCbz  = 8'b10110100;
    localparam logic [7:0] opCbnz = 8'b10110101;
    localparam logic [5:0] opB    = 6'b000101;

    ////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////

    typedef struct packed {
        logic [10:0] opcode;
        regIdx_t     rm;
        logic [5:0]  shamt;
        regIdx_t     rn;
        regIdx_t     rd;
    } rFormat_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        regIdx_t     rn;
        regIdx_t     rd;
    } iFormat_t;

    typedef struct packed {
        logic [10:0] opcode;
        logic [8:0]  offset;
        logic [1:0]  op2;
        regIdx_t     rn;
        regIdx_t     rt;
    } dFormat_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [18:0] offset;
        regIdx_t     rt;
    } cbFormat_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] offset;
    } bFormat_t;

    typedef union packed {
        rFormat_t  r;
        iFormat_t  i;
        dFormat_t  d;
        cbFormat_t cb;
        bFormat_t  b;
    } instr_u;

endpackage

/* pipePkg.sv */
package pipePkg;

    import isaPkg::*;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluEor
    } aluOp_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic   useImm;
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
    } ctrl_t;

    // Decoder output, consumed inside decode stage
    typedef struct packed {
        ctrl_t   ctrl;
        regIdx_t aIdx;
        regIdx_t bIdx;
        regIdx_t rd;
        word_t   imm;
        logic    isCbz;
        logic    isCbnz;
        logic    isB;
    } decoded_t;

    ////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////

    typedef struct packed {
        instrWord_t instr;
        word_t      pc;
    } ifId_t;

    typedef struct packed {
        ctrl_t   ctrl;
        word_t   a;
        word_t   b;
        word_t   imm;
        regIdx_t rd;
    } idEx_t;

    typedef struct packed {
        logic    memRead;
        logic    regWrite;
        word_t   result;
        regIdx_t rd;
    } exMem_t;

    typedef struct packed {
        word_t addr;
        word_t storeData;
        logic  storeEn;
    } memReq_t;

    typedef struct packed {
        logic    regWrite;
        regIdx_t rd;
        word_t   data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* fetchStage.sv */
`timescale 1ns/100ps

module fetchStage
    import isaPkg::*, pipePkg::*;
#(
    parameter word_t resetPc = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  redirect_t  redirect,
    input  instrWord_t instr,
    output word_t      instrAddr,
    output ifId_t      ifId
);

    word_t pc;
    word_t nextPc;

    // Branch resolved in decode overrides the sequential step
    assign nextPc = redirect.taken ? redirect.target : pc + instrBytes;
    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // Fetched word travels with its own address
    always_ff @(posedge clk) begin
        if (reset) begin
            ifId <= '0;
        end else begin
            ifId.instr <= instr;
            ifId.pc <= pc;
        end
    end

    // Redirect targets come from word offsets, so alignment must survive branches
    pcAligned: assert property (@(posedge clk) disable iff (reset) instrAddr[1:0] == 2'b00);

endmodule

/* instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder
    import isaPkg::*, pipePkg::*;
(
    input  instr_u   instr,
    output decoded_t dec
);

    // ALU op with writeback, all other control low
    function automatic ctrl_t aluCtrl(aluOp_t op, logic useImm);
        ctrl_t c;
        c = '0;
        c.aluOp = op;
        c.useImm = useImm;
        c.regWrite = 1'b1;
        return c;
    endfunction

    always_comb begin
        dec = '0;
        dec.aIdx = instr.r.rn;
        dec.bIdx = instr.r.rm;
        dec.rd = instr.r.rd;

        // Widest opcode field first
        case (instr.r.opcode)
            opAdd: dec.ctrl = aluCtrl(aluAdd, 1'b0);
            opSub: dec.ctrl = aluCtrl(aluSub, 1'b0);
            opAnd: dec.ctrl = aluCtrl(aluAnd, 1'b0);
            opOrr: dec.ctrl = aluCtrl(aluOrr, 1'b0);
            opEor: dec.ctrl = aluCtrl(aluEor, 1'b0);
            opLdur: begin
                dec.ctrl = aluCtrl(aluAdd, 1'b1);
                dec.ctrl.memRead = 1'b1;
                dec.imm = {{55{instr.d.offset[8]}}, instr.d.offset};
            end
            opStur: begin
                dec.ctrl = aluCtrl(aluAdd, 1'b1);
                dec.ctrl.memWrite = 1'b1;
                dec.ctrl.regWrite = 1'b0;
                dec.bIdx = instr.d.rt;
                dec.imm = {{55{instr.d.offset[8]}}, instr.d.offset};
            end
            default: begin
                // I format immediates are unsigned
                dec.imm = {52'd0, instr.i.imm};
                case (instr.i.opcode)
                    opAddi: dec.ctrl = aluCtrl(aluAdd, 1'b1);
                    opSubi: dec.ctrl = aluCtrl(aluSub, 1'b1);
                    opAndi: dec.ctrl = aluCtrl(aluAnd, 1'b1);
                    opOrri: dec.ctrl = aluCtrl(aluOrr, 1'b1);
                    opEori: dec.ctrl = aluCtrl(aluEor, 1'b1);
                    default: begin
                        dec.isCbz = (instr.cb.opcode == opCbz);
                        dec.isCbnz = (instr.cb.opcode == opCbnz);
                        dec.isB = (instr.b.opcode == opB);
                    end
                endcase
            end
        endcase

        // Branch offsets count words
        if (dec.isCbz || dec.isCbnz) begin
            dec.bIdx = instr.cb.rt;
            dec.imm = {{43{instr.cb.offset[18]}}, instr.cb.offset, 2'b00};
        end
        if (dec.isB) begin
            dec.imm = {{36{instr.b.offset[25]}}, instr.b.offset, 2'b00};
        end

        // X31 discards writes
        if (dec.rd == zeroReg) begin
            dec.ctrl.regWrite = 1'b0;
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/100ps

module regFile
    import isaPkg::*, pipePkg::*;
(
    input  logic    clk,
    input  regIdx_t aIdx,
    input  regIdx_t bIdx,
    input  wb_t     wb,
    output word_t   a,
    output word_t   b
);

    // X0 to X30 only, X31 is not stored
    word_t regs [0:30];

    always_ff @(posedge clk) begin
        if (wb.regWrite && wb.rd != zeroReg) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Zero register, then same-cycle bypass from writeback
    assign a = (aIdx == zeroReg) ? '0 :
               (wb.regWrite && wb.rd == aIdx) ? wb.data : regs[aIdx];
    assign b = (bIdx == zeroReg) ? '0 :
               (wb.regWrite && wb.rd == bIdx) ? wb.data : regs[bIdx];

    // Decoder drops regWrite for X31, so writeback never carries it
    noZeroRegWrite: assert property (
        @(posedge clk) wb.regWrite !== 1'b1 || wb.rd != zeroReg
    );

endmodule

/* decodeStage.sv */
`timescale 1ns/100ps

module decodeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  ifId_t     ifId,
    input  wb_t       wb,
    output redirect_t redirect,
    output idEx_t     idEx
);

    decoded_t dec;
    word_t    aVal;
    word_t    bVal;

    instrDecoder i_instrDecoder (
        .instr(ifId.instr),
        .dec  (dec)
    );

    regFile i_regFile (
        .clk (clk),
        .aIdx(dec.aIdx),
        .bIdx(dec.bIdx),
        .wb  (wb),
        .a   (aVal),
        .b   (bVal)
    );

    ////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////

    // CBZ/CBNZ test the rt value read on port b
    assign redirect.taken = dec.isB ||
                            (dec.isCbz && bVal == '0) ||
                            (dec.isCbnz && bVal != '0);
    // Target is relative to the branch itself
    assign redirect.target = ifId.pc + dec.imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx.ctrl <= '0;
        end else begin
            idEx.ctrl <= dec.ctrl;
        end
        idEx.a <= aVal;
        idEx.b <= bVal;
        idEx.imm <= dec.imm;
        idEx.rd <= dec.rd;
    end

endmodule

/* executeStage.sv */
`timescale 1ns/100ps

module executeStage
    import isaPkg::*, pipePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  idEx_t   idEx,
    output memReq_t memReq,
    output exMem_t  exMem
);

    word_t opB;
    word_t result;

    assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.b;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  result = idEx.a + opB;
            aluSub:  result = idEx.a - opB;
            aluAnd:  result = idEx.a & opB;
            aluOrr:  result = idEx.a | opB;
            aluEor:  result = idEx.a ^ opB;
            default: result = '0;
        endcase
    end

    // Result doubles as the data address for LDUR/STUR
    always_ff @(posedge clk) begin
        if (reset) begin
            memReq.storeEn <= 1'b0;
            exMem.memRead <= 1'b0;
            exMem.regWrite <= 1'b0;
        end else begin
            memReq.storeEn <= idEx.ctrl.memWrite;
            exMem.memRead <= idEx.ctrl.memRead;
            exMem.regWrite <= idEx.ctrl.regWrite;
        end
        memReq.addr <= result;
        memReq.storeData <= idEx.b;
        exMem.result <= result;
        exMem.rd <= idEx.rd;
    end

    // No decoded opcode both loads and stores
    noLoadStore: assert property (
        @(posedge clk) disable iff (reset) !(idEx.ctrl.memRead && idEx.ctrl.memWrite)
    );

endmodule

/* memWbStage.sv */
`timescale 1ns/100ps

module memWbStage
    import isaPkg::*, pipePkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  exMem_t exMem,
    input  word_t  loadData,
    output wb_t    wb
);

    // Load data is valid in the same cycle as the request address
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.regWrite <= 1'b0;
        end else begin
            wb.regWrite <= exMem.regWrite;
        end
        wb.rd <= exMem.rd;
        if (exMem.memRead) begin
            wb.data <= loadData;
        end else begin
            wb.data <= exMem.result;
        end
    end

endmodule

/* cpuTop.sv */
`timescale 1ns/100ps

module cpuTop
    import isaPkg::*, pipePkg::*;
#(
    parameter word_t resetPc = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  instrWord_t instr,
    input  word_t      loadData,
    output word_t      instrAddr,
    output memReq_t    memReq
);

    ifId_t     ifId;
    redirect_t redirect;
    idEx_t     idEx;
    exMem_t    exMem;
    wb_t       wb;

    fetchStage #(
        .resetPc(resetPc)
    ) i_fetchStage (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .instr    (instr),
        .instrAddr(instrAddr),
        .ifId     (ifId)
    );

    // Writeback feeds the register file inside decode
    decodeStage i_decodeStage (
        .clk     (clk),
        .reset   (reset),
        .ifId    (ifId),
        .wb      (wb),
        .redirect(redirect),
        .idEx    (idEx)
    );

    executeStage i_executeStage (
        .clk   (clk),
        .reset (reset),
        .idEx  (idEx),
        .memReq(memReq),
        .exMem (exMem)
    );

    memWbStage i_memWbStage (
        .clk     (clk),
        .reset   (reset),
        .exMem   (exMem),
        .loadData(loadData),
        .wb      (wb)
    );

endmodule

/* cpuTb.sv */
`timescale 1ns/100ps

module cpuTb
    import isaPkg::*, pipePkg::*;
();

    localparam int imemWords = 256;
    localparam int dmemWords = 64;
    localparam int waitLimit = 2000;

    logic       clk;
    logic       reset;
    instrWord_t instr;
    word_t      loadData;
    word_t      instrAddr;
    memReq_t    memReq;

    instrWord_t imem [0:imemWords-1];
    word_t      dmem [0:dmemWords-1];
    instrWord_t prog[$];
    memReq_t    storeLog[$];
    memReq_t    expStores[$];
    logic [15:0] lfsrState = 16'd81;

    int valueErrors = 0;
    int countErrors = 0;
    int timeoutErrors = 0;

    cpuTop #(
        .resetPc('0)
    ) i_cpuTop (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .loadData (loadData),
        .instrAddr(instrAddr),
        .memReq   (memReq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Combinational memories, nop beyond the program
    assign instr = (instrAddr < imemWords * 4) ? imem[instrAddr[9:2]] : '0;
    assign loadData = (memReq.addr < dmemWords * 8) ? dmem[memReq.addr[8:3]] : '0;

    always @(posedge clk) begin
        if (memReq.storeEn === 1'b1) begin
            storeLog.push_back(memReq);
            if (memReq.addr < dmemWords * 8) begin
                dmem[memReq.addr[8:3]] <= memReq.storeData;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    function automatic word_t randomBits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[62:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Initial data pattern, depends on the full byte address
    function automatic word_t fillWord(word_t addr);
        return {~addr[31:0], addr[31:0]} ^ 64'h5A5A_0000_0000_A5A5;
    endfunction

    function automatic instrWord_t encR(logic [10:0] op, regIdx_t rd, regIdx_t rn, regIdx_t rm);
        return {op, rm, 6'd0, rn, rd};
    endfunction

    function automatic instrWord_t encI(logic [9:0] op, regIdx_t rd, regIdx_t rn,
                                        logic [11:0] imm);
        return {op, imm, rn, rd};
    endfunction

    function automatic instrWord_t encD(logic [10:0] op, regIdx_t rt, regIdx_t rn,
                                        logic [8:0] off);
        return {op, off, 2'b00, rn, rt};
    endfunction

    function automatic instrWord_t encCb(logic [7:0] op, regIdx_t rt, logic [18:0] off);
        return {op, off, rt};
    endfunction

    function automatic instrWord_t encB(logic [25:0] off);
        return {opB, off};
    endfunction

    function automatic memReq_t storeEntry(word_t addr, word_t data);
        memReq_t r;
        r.addr = addr;
        r.storeData = data;
        r.storeEn = 1'b1;
        return r;
    endfunction

    task automatic put(instrWord_t w);
        prog.push_back(w);
    endtask

    // Spacing for a dependent instruction
    task automatic addNops();
        repeat (3) prog.push_back('0);
    endtask

    task automatic startProgram();
        prog.delete();
        expStores.delete();
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic compareReq(string name, int idx, memReq_t expected, memReq_t actual);
        if (expected !== actual) begin
            $display("Error %s store %0d: expected addr=%h data=%h en=%b, actual addr=%h data=%h en=%b",
                     name, idx, expected.addr, expected.storeData, expected.storeEn,
                     actual.addr, actual.storeData, actual.storeEn);
            valueErrors++;
        end
    endtask

    task automatic compareCount(string name, int expected, int actual);
        if (expected != actual) begin
            $display("Error %s store count: expected %0d, actual %0d", name, expected, actual);
            countErrors++;
        end
    endtask

    // Load memories, reset, run until the pipeline drains, check stores
    task automatic runProgram(string name);
        int cycles;
        int n;
        word_t endAddr;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = fillWord(i * 8);
        end
        repeat (16) @(posedge clk);
        storeLog.delete();
        reset <= 1'b0;

        cycles = 0;
        while (storeLog.size() < expStores.size() && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("Timeout in %s: the expected stores did not all appear", name);
            timeoutErrors++;
        end

        // Past the last instruction, so no late store is missed
        endAddr = prog.size() * 4 + 24;
        cycles = 0;
        while (instrAddr < endAddr && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= waitLimit) begin
            $display("Timeout in %s: fetch never reached the end of the program", name);
            timeoutErrors++;
        end

        compareCount(name, expStores.size(), storeLog.size());
        n = (storeLog.size() < expStores.size()) ? storeLog.size() : expStores.size();
        for (int i = 0; i < n; i++) begin
            compareReq(name, i, expStores[i], storeLog[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic testAlu();
        word_t a;
        word_t b;
        word_t imm [4];
        word_t expected [9];
        instrWord_t ops [9];
        startProgram();
        a = randomBits(12);
        b = randomBits(12);
        for (int k = 0; k < 4; k++) begin
            imm[k] = randomBits(12);
        end
        ops[0] = encR(opAdd, 3, 1, 2);
        ops[1] = encR(opSub, 3, 1, 2);
        ops[2] = encR(opAnd, 3, 1, 2);
        ops[3] = encR(opOrr, 3, 1, 2);
        ops[4] = encR(opEor, 3, 1, 2);
        ops[5] = encI(opSubi, 3, 1, imm[0][11:0]);
        ops[6] = encI(opAndi, 3, 1, imm[1][11:0]);
        ops[7] = encI(opOrri, 3, 1, imm[2][11:0]);
        ops[8] = encI(opEori, 3, 1, imm[3][11:0]);
        expected[0] = a + b;
        expected[1] = a - b;
        expected[2] = a & b;
        expected[3] = a | b;
        expected[4] = a ^ b;
        expected[5] = a - imm[0];
        expected[6] = a & imm[1];
        expected[7] = a | imm[2];
        expected[8] = a ^ imm[3];

        put(encI(opAddi, 1, zeroReg, a[11:0]));
        put(encI(opAddi, 2, zeroReg, b[11:0]));
        put(encI(opAddi, 20, zeroReg, 12'd64));
        addNops();
        for (int k = 0; k < 9; k++) begin
            put(ops[k]);
            addNops();
            put(encD(opStur, 3, 20, 9'(8 * k)));
            expStores.push_back(storeEntry(64 + 8 * k, expected[k]));
        end
        addNops();
        runProgram("alu");
    endtask

    task automatic testLoadStore();
        word_t v;
        startProgram();
        v = randomBits(12);
        put(encI(opAddi, 20, zeroReg, 12'd200));
        put(encI(opAddi, 1, zeroReg, v[11:0]));
        addNops();
        put(encD(opStur, 1, 20, 9'(-16)));
        put(encD(opLdur, 2, 20, 9'(-16)));
        put(encD(opLdur, 3, 20, 9'(8)));
        addNops();
        put(encD(opStur, 2, 20, 9'(24)));
        put(encD(opStur, 3, 20, 9'(-192)));
        addNops();
        expStores.push_back(storeEntry(184, v));
        expStores.push_back(storeEntry(224, v));
        expStores.push_back(storeEntry(8, fillWord(208)));
        runProgram("loadStore");
    endtask

    // Branch over one marker store, delay slot always stores
    task automatic addBranchCase(logic [7:0] op, regIdx_t rt, word_t rtValue, int k);
        logic taken;
        taken = (op == opCbz) ? (rtValue == 0) : (rtValue != 0);
        put(encCb(op, rt, 19'(3)));
        put(encD(opStur, 2, 20, 9'(16 * k)));
        put(encD(opStur, 3, 20, 9'(16 * k + 8)));
        expStores.push_back(storeEntry(256 + 16 * k, 64'd5));
        if (!taken) begin
            expStores.push_back(storeEntry(256 + 16 * k + 8, 64'd7));
        end
    endtask

    task automatic testBranches();
        startProgram();
        put(encI(opAddi, 1, zeroReg, 12'd0));
        put(encI(opAddi, 2, zeroReg, 12'd5));
        put(encI(opAddi, 3, zeroReg, 12'd7));
        put(encI(opAddi, 20, zeroReg, 12'd256));
        addNops();
        addBranchCase(opCbz, 1, 64'd0, 0);
        addBranchCase(opCbz, 2, 64'd5, 1);
        addBranchCase(opCbnz, 2, 64'd5, 2);
        addBranchCase(opCbnz, 1, 64'd0, 3);
        addNops();
        runProgram("branches");
    endtask

    task automatic testLoop();
        word_t n;
        startProgram();
        n = randomBits(3) + 1;
        put(encI(opAddi, 1, zeroReg, n[11:0]));
        put(encI(opAddi, 20, zeroReg, 12'd320));
        put(encI(opAddi, 5, zeroReg, 12'd85));
        addNops();
        // Forward jump over two markers
        put(encB(26'(4)));
        put(encD(opStur, 1, 20, 9'(0)));
        put(encD(opStur, 5, 20, 9'(8)));
        put(encD(opStur, 5, 20, 9'(8)));
        // Loop body at word 10
        put(encI(opSubi, 1, 1, 12'd1));
        addNops();
        put(encCb(opCbz, 1, 19'(6)));
        put(encD(opStur, 1, 20, 9'(16)));
        put(encB(26'(-6)));
        put('0);
        put(encD(opStur, 5, 20, 9'(8)));
        put(encD(opStur, 5, 20, 9'(8)));
        // Exit at word 20
        put(encD(opStur, 1, 20, 9'(32)));
        addNops();

        expStores.push_back(storeEntry(320, n));
        for (int i = int'(n) - 1; i >= 0; i--) begin
            expStores.push_back(storeEntry(336, i));
        end
        expStores.push_back(storeEntry(352, 64'd0));
        runProgram("loop");
    endtask

    task automatic testZeroReg();
        startProgram();
        put(encI(opAddi, zeroReg, zeroReg, 12'd123));
        put(encI(opAddi, 1, zeroReg, 12'd9));
        put(encI(opAddi, 20, zeroReg, 12'd400));
        addNops();
        put(encD(opStur, zeroReg, 20, 9'(0)));
        // Undecoded words, rd fields point at X1
        put({11'h7FF, 5'd2, 6'd0, 5'd1, 5'd1});
        put(32'hDEAD_BEE1);
        addNops();
        put(encD(opStur, 1, 20, 9'(8)));
        addNops();
        expStores.push_back(storeEntry(400, 64'd0));
        expStores.push_back(storeEntry(408, 64'd9));
        runProgram("zeroReg");
    endtask

    initial begin
        reset = 1'b1;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = fillWord(i * 8);
        end

        testAlu();
        testLoadStore();
        testBranches();
        testLoop();
        testZeroReg();

        $display("Errors: %0d value, %0d count, %0d timeout",
                 valueErrors, countErrors, timeoutErrors);
        if (valueErrors + countErrors + timeoutErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
isaPkg.sv
pipePkg.sv
fetchStage.sv
instrDecoder.sv
regFile.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
cpuTop.sv
cpuTb.sv
